/* hw/sub_mult_pkg.sv */
package sub_mult_pkg;

  // Sample widths, shared by data, grid and scale
  localparam int SAMPLE_W = 16;
  localparam int RSLT_W   = 16;

  // Full precision of difference times scale
  localparam int PROD_W   = SAMPLE_W + SAMPLE_W;

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic signed [SAMPLE_W-1:0] scale_t;

  // Subtraction result, wraps at SAMPLE_W
  typedef logic signed [SAMPLE_W-1:0] diff_t;

  typedef logic signed [PROD_W-1:0]   prod_t;
  typedef logic signed [RSLT_W-1:0]   result_t;

  // One beat of any input channel
  typedef struct packed {
    sample_t sample;
    logic    last;
  } chan_beat_t;

  // Three channel heads joined into one beat
  typedef struct packed {
    sample_t data;
    sample_t grid;
    scale_t  scale;
    logic    last;
  } joined_beat_t;

  // Output of the subtract stage, scale rides along
  typedef struct packed {
    diff_t  diff;
    scale_t scale;
    logic   last;
  } diff_beat_t;

  typedef struct packed {
    result_t rslt;
    logic    last;
  } result_beat_t;

endpackage

/* hw/stream_skid_reg.sv */
`timescale 1ns/100ps

module stream_skid_reg (
  input  logic                     clk,
  input  logic                     arst_n,
  input  sub_mult_pkg::chan_beat_t in_beat,
  input  logic                     in_valid,
  output logic                     in_ready,
  output sub_mult_pkg::chan_beat_t out_beat,
  output logic                     out_valid,
  input  logic                     out_ready
);
  import sub_mult_pkg::*;

  // Main entry drives the output, skid entry catches a beat during a stall
  chan_beat_t main_beat;
  chan_beat_t skid_beat;
  logic       main_valid;
  logic       skid_valid;
  logic       ready_q;

  logic       wr;
  logic       rd;
  logic       main_valid_nxt;
  logic       skid_valid_nxt;
  logic       main_load;
  logic       skid_load;

  assign wr = in_valid & ready_q;
  assign rd = main_valid & out_ready;

  always_comb begin
    main_valid_nxt = main_valid;
    skid_valid_nxt = skid_valid;
    main_load      = 1'b0;
    skid_load      = 1'b0;
    if (!main_valid || rd) begin
      // Main entry is free this edge, refill from skid first
      main_valid_nxt = skid_valid | wr;
      skid_valid_nxt = 1'b0;
      main_load      = skid_valid | wr;
    end else if (wr) begin
      skid_valid_nxt = 1'b1;
      skid_load      = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
      ready_q    <= 1'b0;
    end else begin
      main_valid <= main_valid_nxt;
      skid_valid <= skid_valid_nxt;
      // Ready drops only with both entries occupied
      ready_q    <= ~skid_valid_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (main_load) begin
      main_beat <= skid_valid ? skid_beat : in_beat;
    end
    if (skid_load) begin
      skid_beat <= in_beat;
    end
  end

  assign in_ready  = ready_q;
  assign out_beat  = main_beat;
  assign out_valid = main_valid;

  a_no_overflow : assert property (
    @(posedge clk) disable iff (!arst_n)
    wr |-> !(main_valid && skid_valid)
  );

  a_out_stable : assert property (
    @(posedge clk) disable iff (!arst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_beat))
  );

endmodule

/* hw/frame_align.sv */
`timescale 1ns/100ps

module frame_align (
  input  logic                       clk,
  input  logic                       arst_n,
  input  sub_mult_pkg::chan_beat_t   data_beat,
  input  logic                       data_valid,
  output logic                       data_ready,
  input  sub_mult_pkg::chan_beat_t   grid_beat,
  input  logic                       grid_valid,
  output logic                       grid_ready,
  input  sub_mult_pkg::chan_beat_t   scale_beat,
  input  logic                       scale_valid,
  output logic                       scale_ready,
  output sub_mult_pkg::joined_beat_t join_beat,
  output logic                       join_valid,
  input  logic                       join_ready
);
  import sub_mult_pkg::*;

  chan_beat_t data_head;
  chan_beat_t grid_head;
  chan_beat_t scale_head;
  logic       data_head_valid;
  logic       grid_head_valid;
  logic       scale_head_valid;
  logic       data_pop;
  logic       grid_pop;
  logic       scale_pop;
  logic       all_valid;
  logic       joint_last;
  logic       xfer;

  stream_skid_reg data_reg (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_beat   (data_beat),
    .in_valid  (data_valid),
    .in_ready  (data_ready),
    .out_beat  (data_head),
    .out_valid (data_head_valid),
    .out_ready (data_pop)
  );

  stream_skid_reg grid_reg (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_beat   (grid_beat),
    .in_valid  (grid_valid),
    .in_ready  (grid_ready),
    .out_beat  (grid_head),
    .out_valid (grid_head_valid),
    .out_ready (grid_pop)
  );

  stream_skid_reg scale_reg (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_beat   (scale_beat),
    .in_valid  (scale_valid),
    .in_ready  (scale_ready),
    .out_beat  (scale_head),
    .out_valid (scale_head_valid),
    .out_ready (scale_pop)
  );

  assign all_valid  = data_head_valid & grid_head_valid & scale_head_valid;
  assign joint_last = data_head.last & grid_head.last & scale_head.last;
  assign xfer       = all_valid & join_ready;

  // A channel sitting on its last beat repeats it until every frame ends
  assign data_pop  = xfer & (~data_head.last | joint_last);
  assign grid_pop  = xfer & (~grid_head.last | joint_last);
  assign scale_pop = xfer & (~scale_head.last | joint_last);

  assign join_valid      = all_valid;
  assign join_beat.data  = data_head.sample;
  assign join_beat.grid  = grid_head.sample;
  assign join_beat.scale = scale_head.sample;
  assign join_beat.last  = joint_last;

  // Held channels keep their last beat at the head until the joint last
  a_hold_last : assert property (
    @(posedge clk) disable iff (!arst_n)
    (xfer && !joint_last) |=>
      (!$past(data_head.last) || $stable(data_head)) &&
      (!$past(grid_head.last) || $stable(grid_head)) &&
      (!$past(scale_head.last) || $stable(scale_head))
  );

endmodule

/* hw/sub_stage.sv */
`timescale 1ns/100ps

module sub_stage (
  input  logic                       clk,
  input  logic                       arst_n,
  input  sub_mult_pkg::joined_beat_t join_beat,
  input  logic                       join_valid,
  output logic                       join_ready,
  output sub_mult_pkg::diff_beat_t   diff_beat,
  output logic                       diff_valid,
  input  logic                       diff_ready
);
  import sub_mult_pkg::*;

  diff_beat_t beat_q;
  diff_t      diff_nxt;
  logic       valid_q;
  logic       load;

  // Wraps to SAMPLE_W like the input format
  assign diff_nxt = diff_t'(join_beat.data - join_beat.grid);

  // Accept when empty or when the held beat leaves this edge
  assign join_ready = ~valid_q | diff_ready;
  assign load       = join_valid & join_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else if (join_ready) begin
      valid_q <= join_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      beat_q.diff  <= diff_nxt;
      beat_q.scale <= join_beat.scale;
      beat_q.last  <= join_beat.last;
    end
  end

  assign diff_beat  = beat_q;
  assign diff_valid = valid_q;

endmodule

/* hw/mult_stage.sv */
`timescale 1ns/100ps

module mult_stage #(
  parameter int DATA_FRAC  = 12,
  parameter int SCALE_FRAC = 12,
  parameter int RSLT_FRAC  = 12
) (
  input  logic                       clk,
  input  logic                       arst_n,
  input  sub_mult_pkg::diff_beat_t   diff_beat,
  input  logic                       diff_valid,
  output logic                       diff_ready,
  output sub_mult_pkg::result_beat_t rslt_beat,
  output logic                       rslt_valid,
  input  logic                       rslt_ready
);
  import sub_mult_pkg::*;

  // Product carries DATA_FRAC + SCALE_FRAC fractional bits
  localparam int RSLT_SHIFT = DATA_FRAC + SCALE_FRAC - RSLT_FRAC;

  prod_t        prod;
  prod_t        prod_shifted;
  result_t      rslt_nxt;
  result_beat_t beat_q;
  logic         valid_q;
  logic         load;

  assign prod         = prod_t'(diff_beat.diff) * prod_t'(diff_beat.scale);
  assign prod_shifted = prod >>> RSLT_SHIFT;

  // Keep low bits only, overflow wraps
  assign rslt_nxt = result_t'(prod_shifted);

  assign diff_ready = ~valid_q | rslt_ready;
  assign load       = diff_valid & diff_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else if (diff_ready) begin
      valid_q <= diff_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      beat_q.rslt <= rslt_nxt;
      beat_q.last <= diff_beat.last;
    end
  end

  assign rslt_beat  = beat_q;
  assign rslt_valid = valid_q;

  a_rslt_stable : assert property (
    @(posedge clk) disable iff (!arst_n)
    (rslt_valid && !rslt_ready) |=> (rslt_valid && $stable(rslt_beat))
  );

endmodule

/* hw/sub_mult.sv */
`timescale 1ns/100ps

module sub_mult #(
  parameter int DATA_FRAC  = 12,
  parameter int SCALE_FRAC = 12,
  parameter int RSLT_FRAC  = 12
) (
  input  logic                       clk,
  input  logic                       arst_n,
  input  sub_mult_pkg::chan_beat_t   data_beat,
  input  logic                       data_valid,
  output logic                       data_ready,
  input  sub_mult_pkg::chan_beat_t   grid_beat,
  input  logic                       grid_valid,
  output logic                       grid_ready,
  input  sub_mult_pkg::chan_beat_t   scale_beat,
  input  logic                       scale_valid,
  output logic                       scale_ready,
  output sub_mult_pkg::result_beat_t rslt_beat,
  output logic                       rslt_valid,
  input  logic                       rslt_ready
);
  import sub_mult_pkg::*;

  joined_beat_t join_beat;
  logic         join_valid;
  logic         join_ready;
  diff_beat_t   diff_beat;
  logic         diff_valid;
  logic         diff_ready;

  // Skid registers and frame length alignment
  frame_align align0 (
    .clk         (clk),
    .arst_n      (arst_n),
    .data_beat   (data_beat),
    .data_valid  (data_valid),
    .data_ready  (data_ready),
    .grid_beat   (grid_beat),
    .grid_valid  (grid_valid),
    .grid_ready  (grid_ready),
    .scale_beat  (scale_beat),
    .scale_valid (scale_valid),
    .scale_ready (scale_ready),
    .join_beat   (join_beat),
    .join_valid  (join_valid),
    .join_ready  (join_ready)
  );

  sub_stage sub0 (
    .clk        (clk),
    .arst_n     (arst_n),
    .join_beat  (join_beat),
    .join_valid (join_valid),
    .join_ready (join_ready),
    .diff_beat  (diff_beat),
    .diff_valid (diff_valid),
    .diff_ready (diff_ready)
  );

  mult_stage #(
    .DATA_FRAC  (DATA_FRAC),
    .SCALE_FRAC (SCALE_FRAC),
    .RSLT_FRAC  (RSLT_FRAC)
  ) mult0 (
    .clk        (clk),
    .arst_n     (arst_n),
    .diff_beat  (diff_beat),
    .diff_valid (diff_valid),
    .diff_ready (diff_ready),
    .rslt_beat  (rslt_beat),
    .rslt_valid (rslt_valid),
    .rslt_ready (rslt_ready)
  );

endmodule

/* dv/sub_mult_tasks.svh */
`ifndef SUB_MULT_TASKS_SVH
`define SUB_MULT_TASKS_SVH

task automatic check_result(input result_t got, input result_t exp, input string what);
  if (got !== exp) begin
    $display("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp);
    fail_run();
  end
endtask

task automatic check_last(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    $display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
    fail_run();
  end
endtask

task automatic drive_chan(input int ch, input logic valid, input chan_beat_t beat);
  case (ch)
    0: begin
      data_valid = valid;
      data_beat  = beat;
    end
    1: begin
      grid_valid = valid;
      grid_beat  = beat;
    end
    default: begin
      scale_valid = valid;
      scale_beat  = beat;
    end
  endcase
endtask

function automatic logic chan_ready(input int ch);
  case (ch)
    0: return data_ready;
    1: return grid_ready;
    default: return scale_ready;
  endcase
endfunction

task automatic clear_frames();
  n_frames = 0;
  for (int ch = 0; ch < 3; ch++) begin
    fill_pos[ch] = 0;
  end
endtask

// One frame on each channel with lengths for data, grid and scale
task automatic add_frame(input int len_data, input int len_grid, input int len_scale);
  int len [0:2];
  len[0] = len_data;
  len[1] = len_grid;
  len[2] = len_scale;
  for (int ch = 0; ch < 3; ch++) begin
    for (int i = 0; i < len[ch]; i++) begin
      vals[ch][fill_pos[ch]] = sample_t'($random(seed));
      fill_pos[ch]++;
    end
    frame_len[ch][n_frames] = len[ch];
  end
  n_frames++;
endtask

// Ready is registered, so its value at the falling edge decides the transfer
task automatic send_channel(input int ch, input int gap_max);
  int         pos;
  int         gap;
  logic       accepted;
  chan_beat_t beat;
  pos  = 0;
  beat = '0;
  for (int f = 0; f < n_frames; f++) begin
    for (int i = 0; i < frame_len[ch][f]; i++) begin
      gap = {$random(seed)} % (gap_max + 1);
      repeat (gap) begin
        @(negedge clk);
        drive_chan(ch, 1'b0, beat);
      end
      beat.sample = vals[ch][pos];
      beat.last   = (i == frame_len[ch][f] - 1);
      @(negedge clk);
      drive_chan(ch, 1'b1, beat);
      accepted = 1'b0;
      while (!accepted) begin
        accepted = chan_ready(ch);
        @(posedge clk);
        if (!accepted) @(negedge clk);
      end
      pos++;
    end
  end
  @(negedge clk);
  drive_chan(ch, 1'b0, beat);
endtask

task automatic collect_results(input int stall_pct);
  int           got;
  result_beat_t beat;
  got = 0;
  while (got < exp_rslt.size()) begin
    @(negedge clk);
    rslt_ready = ({$random(seed)} % 100) >= stall_pct;
    if (rslt_valid && rslt_ready) begin
      beat = rslt_beat;
      check_result(beat.rslt, exp_rslt[got], $sformatf("result beat %0d", got));
      check_last(beat.last, exp_last[got], $sformatf("last of beat %0d", got));
      got++;
    end
  end
  @(negedge clk);
  rslt_ready = 1'b1;
endtask

task automatic run_frames(input int gap_max, input int stall_pct, input string what);
  build_expected();
  fork
    send_channel(0, gap_max);
    send_channel(1, gap_max);
    send_channel(2, gap_max);
    collect_results(stall_pct);
  join
  // Nothing may follow the expected results
  repeat (4) begin
    @(negedge clk);
    check_last(rslt_valid, 1'b0, {"rslt_valid after ", what});
  end
endtask

task automatic test_reset_state();
  arst_n = 1'b0;
  repeat (4) begin
    @(negedge clk);
    check_last(rslt_valid, 1'b0, "rslt_valid in reset");
  end
  arst_n = 1'b1;
  @(negedge clk);
  check_last(rslt_valid, 1'b0, "rslt_valid after reset");
  check_last(data_ready, 1'b1, "data_ready after reset");
  check_last(grid_ready, 1'b1, "grid_ready after reset");
  check_last(scale_ready, 1'b1, "scale_ready after reset");
endtask

task automatic test_equal_frames();
  clear_frames();
  add_frame(8, 8, 8);
  run_frames(0, 0, "equal frames");
endtask

task automatic test_unequal_frames();
  clear_frames();
  add_frame(5, 3, 1);
  run_frames(0, 0, "unequal frames");
endtask

task automatic test_back_pressure();
  clear_frames();
  add_frame(16, 16, 16);
  run_frames(0, 50, "back-pressure");
endtask

// Output lengths 6, 7, 5 and 6
task automatic test_back_to_back();
  clear_frames();
  add_frame(4, 6, 2);
  add_frame(3, 3, 7);
  add_frame(1, 5, 5);
  add_frame(6, 2, 4);
  run_frames(3, 25, "back-to-back frames");
endtask

`endif

/* dv/sub_mult_tb.sv */
`timescale 1ns/100ps

module sub_mult_tb;
  import sub_mult_pkg::*;

  localparam int CLK_PERIOD  = 20;
  localparam int MODEL_SHIFT = 12;
  localparam int MAX_BEATS   = 64;
  localparam int MAX_FRAMES  = 8;

  // Output beats over tests 2 to 5
  localparam int TEST_BEATS  = 8 + 5 + 16 + 24;
  localparam int WATCHDOG_NS = TEST_BEATS * 40 * CLK_PERIOD;

  logic         clk;
  logic         arst_n;
  chan_beat_t   data_beat;
  logic         data_valid;
  logic         data_ready;
  chan_beat_t   grid_beat;
  logic         grid_valid;
  logic         grid_ready;
  chan_beat_t   scale_beat;
  logic         scale_valid;
  logic         scale_ready;
  result_beat_t rslt_beat;
  logic         rslt_valid;
  logic         rslt_ready;

  integer       seed;

  // Stimulus per channel, 0 data, 1 grid, 2 scale
  sample_t      vals [0:2][0:MAX_BEATS-1];
  int           frame_len [0:2][0:MAX_FRAMES-1];
  int           fill_pos [0:2];
  int           n_frames;

  result_t      exp_rslt [$];
  logic         exp_last [$];

  sub_mult dut0 (
    .clk         (clk),
    .arst_n      (arst_n),
    .data_beat   (data_beat),
    .data_valid  (data_valid),
    .data_ready  (data_ready),
    .grid_beat   (grid_beat),
    .grid_valid  (grid_valid),
    .grid_ready  (grid_ready),
    .scale_beat  (scale_beat),
    .scale_valid (scale_valid),
    .scale_ready (scale_ready),
    .rslt_beat   (rslt_beat),
    .rslt_valid  (rslt_valid),
    .rslt_ready  (rslt_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic fail_run();
    $display("Result: FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog: the run timed out at %0t before all tests finished", $time);
    fail_run();
  end

  // (data - grid) wraps to 16 bits, full product, arithmetic shift, low 16 bits
  function automatic result_t model_result(input sample_t d, input sample_t g, input scale_t s);
    logic signed [15:0] diff;
    int                 prod;
    diff = d - g;
    prod = int'(diff) * int'(s);
    return result_t'(prod >>> MODEL_SHIFT);
  endfunction

  // Longest frame sets the length, shorter channels repeat their last sample
  task automatic build_expected();
    int      pos [0:2];
    int      longest;
    int      idx;
    sample_t pick [0:2];
    exp_rslt.delete();
    exp_last.delete();
    for (int ch = 0; ch < 3; ch++) begin
      pos[ch] = 0;
    end
    for (int f = 0; f < n_frames; f++) begin
      longest = 0;
      for (int ch = 0; ch < 3; ch++) begin
        if (frame_len[ch][f] > longest) longest = frame_len[ch][f];
      end
      for (int k = 0; k < longest; k++) begin
        for (int ch = 0; ch < 3; ch++) begin
          idx      = (k < frame_len[ch][f]) ? k : frame_len[ch][f] - 1;
          pick[ch] = vals[ch][pos[ch] + idx];
        end
        exp_rslt.push_back(model_result(pick[0], pick[1], pick[2]));
        exp_last.push_back(k == longest - 1);
      end
      for (int ch = 0; ch < 3; ch++) begin
        pos[ch] = pos[ch] + frame_len[ch][f];
      end
    end
  endtask

  `include "sub_mult_tasks.svh"

  initial begin
    seed        = 32'h3a11_2f56;
    arst_n      = 1'b0;
    data_beat   = '0;
    data_valid  = 1'b0;
    grid_beat   = '0;
    grid_valid  = 1'b0;
    scale_beat  = '0;
    scale_valid = 1'b0;
    rslt_ready  = 1'b1;
    n_frames    = 0;

    test_reset_state();
    test_equal_frames();
    test_unequal_frames();
    test_back_pressure();
    test_back_to_back();

    $display("Result: PASSED");
    $finish;
  end

endmodule

/* sub_mult.f */
+incdir+dv
hw/sub_mult_pkg.sv
hw/stream_skid_reg.sv
hw/frame_align.sv
hw/sub_stage.sv
hw/mult_stage.sv
hw/sub_mult.sv
dv/sub_mult_tb.sv
